/* arb_top.f */
+incdir+include
logic/arb_cfg_pkg.sv
logic/arb_data_pkg.sv
logic/src_queue.sv
logic/rr_priority_arbiter.sv
logic/out_stage.sv
logic/arb_top.sv
test/arb_props.sv
test/arb_tb.sv

/* Makefile */
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
TOP        := arb_tb
FILELIST   := arb_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Regression failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/arb_tb.sv */
module arb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import arb_cfg_pkg::*;
    import arb_data_pkg::*;

    localparam int SOURCES = DEF_SOURCES;
    localparam int DEPTH = DEF_DEPTH;
    localparam logic [SOURCES-1:0] PRIORITY_MASK = 4'b0001;
    localparam int PRELOAD = 3;     // Words per source in the ordering tests.
    localparam int MIX_CYCLES = 64;
    localparam int DRAIN_LIMIT = 200;
    localparam int TEST_CYCLES = 5 * 12 + 4 * 8 + 2 * PRELOAD * SOURCES * 6
        + 3 * DEPTH + MIX_CYCLES * 4;

    logic CLK;
    logic RST;
    logic [SOURCES-1:0] in_write;
    word_t in_data [SOURCES];
    logic [SOURCES-1:0] reserve;
    logic [SOURCES-1:0] in_full;
    logic out_valid;
    out_beat_t out_beat;
    logic out_ready;

    word_t exp_q [SOURCES][$];      // Words written and not yet seen, per source.
    src_t order_q [$];              // Source of every beat seen since reset.
    logic [31:0] lfsr;
    int mismatch_count;
    int failure_count;
    logic stalled;
    out_beat_t stall_beat;

    arb_top #(
        .SOURCES      (SOURCES),
        .DEPTH        (DEPTH),
        .PRIORITY_MASK(PRIORITY_MASK)
    ) u_arb_top (
        .CLK      (CLK),
        .RST      (RST),
        .in_write (in_write),
        .in_data  (in_data),
        .reserve  (reserve),
        .in_full  (in_full),
        .out_valid(out_valid),
        .out_beat (out_beat),
        .out_ready(out_ready)
    );

    always #4 CLK = ~CLK;

    // Taps 32, 22, 2 and 1 give a maximal length sequence.
    function automatic logic take_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t random_word();
        word_t w;
        for (int b = 0; b < 32; b++) begin
            w[b] = take_bit();
        end
        return w;
    endfunction

    function automatic int pending_words();
        int total;
        total = 0;
        for (int s = 0; s < SOURCES; s++) total += exp_q[s].size();
        return total;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch at %0d ns: %s (got %0h, expected %0h)", $time, msg, actual,
                     expected);
        end
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic take_beat(input out_beat_t b);
        int s;
        s = int'(b.src);
        if (s >= SOURCES) begin
            report_failure($sformatf("beat carries source index %0d, which does not exist", s));
        end else if (exp_q[s].size() == 0) begin
            report_failure($sformatf("beat from source %0d, which had no word pending", s));
        end else begin
            check_value(b.data, exp_q[s].pop_front(), $sformatf("data from source %0d", s));
            order_q.push_back(b.src);
        end
    endtask

    // Beats are taken at the rising edge, where inputs from the falling edge are settled.
    always @(posedge CLK) begin
        if (RST || !out_valid) begin
            stalled = 1'b0;
        end else begin
            if (stalled) check_value(out_beat, stall_beat, "beat changed while stalled");
            stalled = !out_ready;
            stall_beat = out_beat;
            if (out_ready) take_beat(out_beat);
        end
    end

    task automatic drive_write(input int s, input word_t d);
        in_write[s] = 1'b1;
        in_data[s] = d;
        exp_q[s].push_back(d);
    endtask

    task automatic apply_reset();
        @(negedge CLK);
        RST = 1'b1;
        in_write = '0;
        reserve = '0;
        out_ready = 1'b0;
        repeat (10) @(negedge CLK);
        RST = 1'b0;
        for (int s = 0; s < SOURCES; s++) exp_q[s].delete();
        order_q.delete();
    endtask

    task automatic wait_drain(input bit random_ready);
        int cycles;
        cycles = 0;
        while ((pending_words() != 0 || out_valid) && cycles < DRAIN_LIMIT) begin
            @(negedge CLK);
            in_write = '0;
            out_ready = random_ready ? take_bit() : 1'b1;
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) report_failure("output did not drain within the cycle limit");
    endtask

    task automatic test_reset();
        apply_reset();
        @(negedge CLK);
        check_value(out_valid, 1'b0, "out_valid after reset");
        check_value(in_full, '0, "in_full after reset");
    endtask

    task automatic test_latency();
        int lat;
        apply_reset();
        out_ready = 1'b1;
        for (int n = 0; n < 4; n++) begin
            @(negedge CLK);
            drive_write(2, random_word());
            lat = 0;
            do begin
                @(negedge CLK);
                in_write = '0;
                lat++;
            end while (!out_valid && lat < 8);
            check_value(lat, 2, "cycles from write to out_valid");
            check_value(out_beat.src, 2, "source tag of the beat");
            wait_drain(1'b0);
        end
    endtask

    // Preload under reserve, release, then expect masked sources first and round-robin after.
    task automatic test_order(input bit random_ready);
        src_t expected [$];
        apply_reset();
        reserve[1] = 1'b1;
        for (int n = 0; n < PRELOAD; n++) begin
            for (int s = 0; s < SOURCES; s++) begin
                @(negedge CLK);
                in_write = '0;
                out_ready = random_ready ? take_bit() : 1'b1;
                drive_write(s, random_word());
            end
        end
        @(negedge CLK);
        in_write = '0;
        repeat (2) @(negedge CLK);
        check_value(out_valid, 1'b0, "out_valid while a reserve line is high");
        check_value(order_q.size(), 0, "beats seen while a reserve line is high");
        reserve = '0;
        wait_drain(random_ready);
        for (int s = 0; s < SOURCES; s++) begin
            if (PRIORITY_MASK[s]) repeat (PRELOAD) expected.push_back(src_t'(s));
        end
        for (int n = 0; n < PRELOAD; n++) begin
            for (int s = 0; s < SOURCES; s++) begin
                if (!PRIORITY_MASK[s]) expected.push_back(src_t'(s));
            end
        end
        check_value(order_q.size(), expected.size(), "number of beats");
        foreach (expected[i]) begin
            if (i < order_q.size()) check_value(order_q[i], expected[i], "source order");
        end
    endtask

    task automatic test_full_mix();
        int writes;
        logic want;
        apply_reset();
        writes = 0;
        while (writes < 2 * DEPTH && !in_full[3]) begin
            drive_write(3, random_word());
            writes++;
            @(negedge CLK);
            in_write = '0;
        end
        check_value(in_full[3], 1'b1, "in_full of source 3 after filling");
        // One sits in the output register.
        check_value(writes, DEPTH + 1, "words taken before source 3 was full");
        for (int c = 0; c < MIX_CYCLES; c++) begin
            @(negedge CLK);
            in_write = '0;
            out_ready = take_bit();
            for (int s = 0; s < SOURCES; s++) begin
                want = take_bit();
                if (want && !in_full[s]) drive_write(s, random_word());
            end
        end
        wait_drain(1'b1);
    endtask

    initial begin
        CLK = 1'b0;
        RST = 1'b1;
        in_write = '0;
        in_data = '{default: '0};
        reserve = '0;
        out_ready = 1'b0;
        lfsr = 32'hcd1c_0898;
        mismatch_count = 0;
        failure_count = 0;
        stalled = 1'b0;
        test_reset();
        test_latency();
        test_order(1'b0);
        test_order(1'b1);
        test_full_mix();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 8 * 4);
        $display("Watchdog expired after %0d ns with tests still running", TEST_CYCLES * 32);
        $display("Regression failed");
        $finish;
    end

endmodule

/* test/arb_props.sv */
module arb_props #(
    parameter int                 SOURCES = arb_cfg_pkg::DEF_SOURCES,
    parameter logic [SOURCES-1:0] PRIORITY_MASK = '0
) (
    input logic                    CLK,
    input logic                    RST,
    input logic [SOURCES-1:0]      grant,
    input logic [SOURCES-1:0]      reserve,
    input logic                    transfer,
    input arb_cfg_pkg::arb_rule_e  rule,
    input logic                    out_valid,
    input logic                    out_ready,
    input arb_data_pkg::out_beat_t out_beat
);

    timeunit 1ns;
    timeprecision 1ps;

    import arb_cfg_pkg::*;

    grant_onehot: assert property (@(posedge CLK) disable iff (RST) $onehot0(grant))
        else $error("more than one grant bit is high");

    no_transfer_reserved: assert property (@(posedge CLK) disable iff (RST)
        (|reserve) |-> !transfer)
        else $error("transfer while a reserve line is high");

    // Priority grants go to masked sources and round-robin grants to the others.
    rule_grant: assert property (@(posedge CLK) disable iff (RST)
        transfer |-> ((rule == RULE_PRIORITY) == (|(grant & PRIORITY_MASK))))
        else $error("grant does not match the rule that selected it");

    beat_stable: assert property (@(posedge CLK) disable iff (RST)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("output beat changed while stalled");

endmodule

bind rr_priority_arbiter arb_props #(
    .SOURCES(SOURCES),
    .PRIORITY_MASK(PRIORITY_MASK)
) u_arb_props (
    .CLK(CLK), .RST(RST), .grant(grant), .reserve(reserve), .transfer(transfer),
    .rule(rule), .out_valid(1'b0), .out_ready(1'b1), .out_beat('0)
);

// The output stage has no grant or rule, so those inputs sit idle.
bind out_stage arb_props u_stage_props (
    .CLK(CLK), .RST(RST), .grant('0), .reserve('0), .transfer(1'b0),
    .rule(arb_cfg_pkg::RULE_NONE), .out_valid(out_valid), .out_ready(out_ready),
    .out_beat(out_beat)
);

/* logic/arb_top.sv */
module arb_top #(
    parameter int                 SOURCES = arb_cfg_pkg::DEF_SOURCES,
    parameter int                 DEPTH = arb_cfg_pkg::DEF_DEPTH,
    parameter logic [SOURCES-1:0] PRIORITY_MASK = '0
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic [SOURCES-1:0]      in_write,
    input  arb_data_pkg::word_t     in_data [SOURCES],
    input  logic [SOURCES-1:0]      reserve,
    output logic [SOURCES-1:0]      in_full,
    output logic                    out_valid,
    output arb_data_pkg::out_beat_t out_beat,
    input  logic                    out_ready
);

    import arb_data_pkg::*;

    word_t heads [SOURCES];
    logic [SOURCES-1:0] not_empty;
    logic [SOURCES-1:0] grant;
    out_beat_t arb_beat;
    logic transfer;
    logic accept;

    for (genvar s = 0; s < SOURCES; s++) begin : g_queue
        src_queue #(
            .DEPTH(DEPTH)
        ) u_src_queue (
            .CLK       (CLK),
            .RST       (RST),
            .write     (in_write[s]),
            .data      (in_data[s]),
            .pop       (grant[s]),
            .head      (heads[s]),
            .ready_word(not_empty[s]),
            .full      (in_full[s])
        );
    end

    rr_priority_arbiter #(
        .SOURCES      (SOURCES),
        .PRIORITY_MASK(PRIORITY_MASK)
    ) u_arbiter (
        .CLK     (CLK),
        .RST     (RST),
        .req     (not_empty),
        .reserve (reserve),
        .words   (heads),
        .accept  (accept),
        .grant   (grant),
        .transfer(transfer),
        .beat    (arb_beat)
    );

    out_stage u_out_stage (
        .CLK      (CLK),
        .RST      (RST),
        .transfer (transfer),
        .beat     (arb_beat),
        .accept   (accept),
        .out_valid(out_valid),
        .out_beat (out_beat),
        .out_ready(out_ready)
    );

endmodule

/* logic/out_stage.sv */
module out_stage (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    transfer,
    input  arb_data_pkg::out_beat_t beat,
    output logic                    accept,
    output logic                    out_valid,
    output arb_data_pkg::out_beat_t out_beat,
    input  logic                    out_ready
);

    import arb_data_pkg::*;

    out_beat_t beat_q;
    logic valid_q;

    // Room exists when empty or when the sink drains the beat this cycle.
    assign accept = !valid_q || out_ready;

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= 1'b0;
        end else if (transfer) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (transfer) begin
            beat_q <= beat;
        end
    end

    assign out_valid = valid_q;
    assign out_beat = beat_q;

endmodule

/* logic/rr_priority_arbiter.sv */
module rr_priority_arbiter #(
    parameter int                 SOURCES = arb_cfg_pkg::DEF_SOURCES,
    parameter logic [SOURCES-1:0] PRIORITY_MASK = '0
) (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic [SOURCES-1:0]      req,
    input  logic [SOURCES-1:0]      reserve,
    input  arb_data_pkg::word_t     words [SOURCES],
    input  logic                    accept,
    output logic [SOURCES-1:0]      grant,
    output logic                    transfer,
    output arb_data_pkg::out_beat_t beat
);

    import arb_cfg_pkg::*;
    import arb_data_pkg::*;

    `include "arb_log2.svh"

    localparam int SEL_W = (arb_log2(SOURCES) > 0) ? arb_log2(SOURCES) : 1;
    localparam int IDX_W = SEL_W + 1;

    logic [SOURCES-1:0] pri_req;
    logic [SOURCES-1:0] rr_req;
    logic [SEL_W-1:0] res_sel;
    logic [SEL_W-1:0] pri_sel;
    logic [SEL_W-1:0] rr_sel;
    logic [IDX_W-1:0] rr_idx;
    logic [SEL_W-1:0] ptr;     // Next source examined by round-robin.
    logic [SEL_W-1:0] sel;
    logic [SEL_W-1:0] lock_sel;
    arb_rule_e rule;
    arb_rule_e lock_rule;
    logic lock;
    logic pending;

    assign pri_req = req & PRIORITY_MASK;
    assign rr_req = req & ~PRIORITY_MASK;
    assign pending = (|req) && !(|reserve);

    // Downward scans so that the lowest index is the last one written.
    always_comb begin
        res_sel = '0;
        pri_sel = '0;
        for (int i = SOURCES - 1; i >= 0; i--) begin
            if (reserve[i]) res_sel = SEL_W'(i);
            if (pri_req[i]) pri_sel = SEL_W'(i);
        end
    end

    always_comb begin
        rr_sel = ptr;
        rr_idx = '0;
        for (int k = SOURCES - 1; k >= 0; k--) begin
            rr_idx = {1'b0, ptr} + IDX_W'(k);
            if (rr_idx >= IDX_W'(SOURCES)) rr_idx = rr_idx - IDX_W'(SOURCES);
            if (rr_req[rr_idx[SEL_W-1:0]]) rr_sel = rr_idx[SEL_W-1:0];
        end
    end

    always_comb begin
        if (|reserve) begin
            sel = res_sel;
            rule = RULE_RESERVE;
        end else if (lock) begin
            sel = lock_sel;   // Held until the output stage takes it.
            rule = lock_rule;
        end else if (|pri_req) begin
            sel = pri_sel;
            rule = RULE_PRIORITY;
        end else if (|req) begin
            sel = rr_sel;
            rule = RULE_ROUND;
        end else begin
            sel = '0;
            rule = RULE_NONE;
        end
    end

    assign transfer = pending && accept;

    always_comb begin
        grant = '0;
        if (transfer) grant[sel] = 1'b1;
    end

    assign beat.data = words[sel];
    assign beat.src = src_t'(sel);

    always_ff @(posedge CLK) begin
        if (RST) begin
            lock <= 1'b0;
            ptr <= '0;
        end else begin
            lock <= pending && !accept;
            if (transfer && rule == RULE_ROUND) begin
                ptr <= (sel == SEL_W'(SOURCES - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        lock_sel <= sel;
        lock_rule <= rule;
    end

endmodule

/* logic/src_queue.sv */
module src_queue #(
    parameter int DEPTH = arb_cfg_pkg::DEF_DEPTH
) (
    input  logic                CLK,
    input  logic                RST,
    input  logic                write,
    input  arb_data_pkg::word_t data,
    input  logic                pop,
    output arb_data_pkg::word_t head,
    output logic                ready_word,
    output logic                full
);

    import arb_data_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    word_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    always_ff @(posedge CLK) begin
        if (write) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (write) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({write, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // Write and pop together keep the level.
            endcase
        end
    end

    assign head = mem[rd_ptr];
    assign ready_word = (count != '0);
    assign full = (count == CW'(DEPTH));

endmodule

/* logic/arb_data_pkg.sv */
package arb_data_pkg;

    localparam int WORD_W = 32;
    localparam int SRC_W = 8;

    typedef logic [WORD_W-1:0] word_t;

    // Source index carried with each beat.
    typedef logic [SRC_W-1:0] src_t;

    // One beat toward the sink with the word and where it came from.
    typedef struct packed {
        word_t data;
        src_t src;
    } out_beat_t;

endpackage

/* logic/arb_cfg_pkg.sv */
package arb_cfg_pkg;

    // Sizes used when the top level is not overridden.
    localparam int DEF_SOURCES = 4;
    localparam int DEF_DEPTH = 8;

    // Rule behind the arbiter's current selection.
    typedef enum logic [1:0] {
        RULE_NONE,     // Nothing requested and no reserve line high.
        RULE_RESERVE,  // Lowest reserve line wins and nothing moves.
        RULE_PRIORITY, // Lowest requesting source in the fixed mask.
        RULE_ROUND     // Round-robin among the remaining sources.
    } arb_rule_e;

endpackage

/* include/arb_log2.svh */
`ifndef ARB_LOG2_SVH
`define ARB_LOG2_SVH

// Ceiling of log2 with arb_log2(1) returning 0.
function automatic integer arb_log2(input integer value);
    integer result;
    integer span;
    result = 0;
    for (span = 1; span < value; span = span * 2) begin
        result = result + 1;
    end
    return result;
endfunction

`endif
